// File: logic/accel_cfg.svh
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// ==============================
// tile sizing
// ==============================

// request buffer between ingress and multiplier
`define ACCEL_FIFO_DEPTH 4

// register stages from issue to output queue write
`define ACCEL_MUL_STAGES 3

// response queue entries, also the issue credit limit
`define ACCEL_OUT_DEPTH  4

`endif

// File: logic/accelPkg.sv
package accelPkg;

   // ==============================
   // fabric addressing
   // ==============================

   typedef struct packed {
      logic [1:0] x;                  // mesh column
      logic [1:0] y;                  // mesh row
   } tileIdT;                         // 4 bits

   typedef logic [3:0] tagT;          // requester's transaction tag

   // ==============================
   // multiply opcodes
   // ==============================

   // low two bits of the rv32m funct3 for the multiply group
   typedef enum logic [1:0] {
      opMul    = 2'b00,               // low word, sign does not matter
      opMulh   = 2'b01,               // signed x signed, high word
      opMulhsu = 2'b10,               // signed x unsigned, high word
      opMulhu  = 2'b11                // unsigned x unsigned, high word
   } mulOpT;

   // ==============================
   // fabric transaction
   // ==============================

   typedef struct packed {
      tileIdT      dst;               // target tile
      tileIdT      src;               // sender, responses go back here
      tagT         tag;
      mulOpT       op;
      logic [31:0] dataA;             // operand a, result on the way back
      logic [31:0] dataB;             // operand b, zero on the way back
      logic [5:0]  rsvd;              // pad to 84 bits
   } tileTransT;

   // ==============================
   // decoded multiply request
   // ==============================

   typedef struct packed {
      tileIdT      requester;         // taken from the incoming src
      tagT         tag;
      mulOpT       op;
      logic [31:0] opA;
      logic [31:0] opB;
   } mulReqT;                         // 74 bits

endpackage

// File: logic/fabricIngress.sv
`timescale 1ns/1ns

module fabricIngress (
   input  logic                   Clock         ,
   input  logic                   arstN         ,
   input  var accelPkg::tileIdT   localTileId   , // this tile's mesh position
   // ==============================
   // fabric side
   // ==============================
   input  logic                   inFabricValid ,
   input  var accelPkg::tileTransT inFabric     ,
   output logic                   inFabricReady ,
   // ==============================
   // request buffer side
   // ==============================
   output logic                   ingValid      ,
   output accelPkg::mulReqT       ingReq        ,
   input  logic                   ingReady
);

logic              acceptEn;      // opens the port one cycle after reset
logic              inXfer;        // fabric handshake this cycle
logic              isLocal;       // dst matches our id
accelPkg::mulReqT  decReq;        // fields remapped for the multiplier

// ==============================
// destination filter and decode
// ==============================

assign isLocal = (inFabric.dst == localTileId);

always_comb begin
   decReq.requester = inFabric.src;   // answer goes back to sender
   decReq.tag       = inFabric.tag;
   decReq.op        = inFabric.op;
   decReq.opA       = inFabric.dataA;
   decReq.opB       = inFabric.dataB;
end

// take a new one if the slot is empty or drains this cycle
assign inFabricReady = acceptEn && (!ingValid || ingReady);
assign inXfer        = inFabricValid && inFabricReady;

// ==============================
// port enable
// ==============================

always_ff @(posedge Clock or negedge arstN) begin
   if (!arstN) begin
      acceptEn <= 1'b0;               // closed while in reset
   end else begin
      acceptEn <= 1'b1;               // open from the first cycle after
   end
end

// ==============================
// one-entry output register
// ==============================

always_ff @(posedge Clock or negedge arstN) begin
   if (!arstN) begin
      ingValid <= 1'b0;
   end else if (inXfer && isLocal) begin
      ingValid <= 1'b1;               // new request, replaces a drained one
   end else if (ingReady) begin
      ingValid <= 1'b0;               // drained, or misrouted one swallowed
   end
end

always_ff @(posedge Clock) begin
   if (inXfer && isLocal) begin
      ingReq <= decReq;               // payload only moves with valid
   end
end

endmodule

// File: logic/reqFifo.sv
`timescale 1ns/1ns
`include "accel_cfg.svh"

module reqFifo (
   input  logic                Clock     ,
   input  logic                arstN     ,
   // ==============================
   // write side, from ingress
   // ==============================
   input  logic                ingValid  ,
   input  var accelPkg::mulReqT ingReq   ,
   output logic                ingReady  ,
   // ==============================
   // read side, to multiplier
   // ==============================
   output logic                fifoValid ,
   output accelPkg::mulReqT    fifoReq   ,
   input  logic                fifoReady
);

localparam int Depth = `ACCEL_FIFO_DEPTH;
localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
localparam int CntW  = $clog2(Depth + 1);

accelPkg::mulReqT  mem [Depth];   // circular storage
logic [PtrW-1:0]   wrPtr;
logic [PtrW-1:0]   rdPtr;
logic [CntW-1:0]   count;         // entries held, 0..Depth
logic              full;
logic              empty;
logic              wrEn;
logic              rdEn;

assign full  = (count == CntW'(Depth));
assign empty = (count == '0);

// a full buffer still takes a write when the head leaves in the same cycle
assign ingReady  = !full || fifoReady;
assign fifoValid = !empty;
assign fifoReq   = mem[rdPtr];        // head, first in first out

assign wrEn = ingValid && ingReady;
assign rdEn = fifoValid && fifoReady;

// ==============================
// storage
// ==============================

always_ff @(posedge Clock) begin
   if (wrEn) begin
      mem[wrPtr] <= ingReq;
   end
end

// ==============================
// pointers and count
// ==============================

always_ff @(posedge Clock or negedge arstN) begin
   if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
   end else begin
      if (wrEn) begin
         wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;   // wrap
      end
      if (rdEn) begin
         rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({wrEn, rdEn})
         2'b10:   count <= count + 1'b1;
         2'b01:   count <= count - 1'b1;
         default: count <= count;     // both or neither
      endcase
   end
end

endmodule

// File: logic/mulUnit.sv
`timescale 1ns/1ns
`include "accel_cfg.svh"

module mulUnit (
   input  logic                 Clock          ,
   input  logic                 arstN          ,
   input  var accelPkg::tileIdT localTileId    , // goes out as src
   // ==============================
   // request side, from the buffer
   // ==============================
   input  logic                 fifoValid      ,
   input  var accelPkg::mulReqT fifoReq        ,
   output logic                 fifoReady      ,
   // ==============================
   // fabric out
   // ==============================
   output logic                 outFabricValid ,
   output accelPkg::tileTransT  outFabric      ,
   input  logic                 fabReady
);

localparam int Stages   = `ACCEL_MUL_STAGES;
localparam int OutDepth = `ACCEL_OUT_DEPTH;
localparam int PtrW     = (OutDepth > 1) ? $clog2(OutDepth) : 1;
localparam int CntW     = $clog2(OutDepth + 1);

// sideband plus product, moves down the pipe
typedef struct packed {
   accelPkg::tileIdT requester;
   accelPkg::tagT    tag;
   accelPkg::mulOpT  op;
   logic [63:0]      prod;
} stgT;

// one response waiting for the fabric
typedef struct packed {
   accelPkg::tileIdT requester;
   accelPkg::tagT    tag;
   accelPkg::mulOpT  op;
   logic [31:0]      result;
} rspT;

logic                issue;           // request taken this cycle
logic                aSigned;
logic                bSigned;
logic signed [32:0]  extA;            // one extra bit carries the sign
logic signed [32:0]  extB;
logic signed [65:0]  fullProd;
logic [Stages-1:0]   stgValid;
stgT                 stgData [Stages];
stgT                 lastStg;
rspT                 rspIn;           // selected word, queue write data
rspT                 outQ [OutDepth];
rspT                 headRsp;
logic [PtrW-1:0]     wrPtr;
logic [PtrW-1:0]     rdPtr;
logic [CntW-1:0]     outCnt;          // queued responses
logic [CntW-1:0]     creditCnt;       // in flight plus queued
logic                push;
logic                pop;

// ==============================
// issue and operand extension
// ==============================

// never more in flight than the queue can absorb
assign fifoReady = (creditCnt < CntW'(OutDepth));
assign issue     = fifoValid && fifoReady;

assign aSigned = (fifoReq.op != accelPkg::opMulhu);     // mul, mulh, mulhsu
assign bSigned = (fifoReq.op == accelPkg::opMulh) ||
                 (fifoReq.op == accelPkg::opMul);

always_comb begin
   extA     = {aSigned & fifoReq.opA[31], fifoReq.opA};
   extB     = {bSigned & fifoReq.opB[31], fifoReq.opB};
   fullProd = extA * extB;            // 33x33 signed covers all four forms
end

// ==============================
// multiplier pipeline
// ==============================

always_ff @(posedge Clock or negedge arstN) begin
   if (!arstN) begin
      stgValid <= '0;
   end else begin
      stgValid[0] <= issue;
      for (int i = 1; i < Stages; i++) begin
         stgValid[i] <= stgValid[i-1];
      end
   end
end

always_ff @(posedge Clock) begin
   if (issue) begin
      stgData[0].requester <= fifoReq.requester;
      stgData[0].tag       <= fifoReq.tag;
      stgData[0].op        <= fifoReq.op;
      stgData[0].prod      <= fullProd[63:0];     // top two bits are sign only
   end
   for (int i = 1; i < Stages; i++) begin
      stgData[i] <= stgData[i-1];     // retimed into the multiplier by synthesis
   end
end

// ==============================
// word select into the queue
// ==============================

assign lastStg = stgData[Stages-1];
assign push    = stgValid[Stages-1];

always_comb begin
   rspIn.requester = lastStg.requester;
   rspIn.tag       = lastStg.tag;
   rspIn.op        = lastStg.op;
   rspIn.result    = (lastStg.op == accelPkg::opMul) ? lastStg.prod[31:0]
                                                     : lastStg.prod[63:32];
end

always_ff @(posedge Clock) begin
   if (push) begin
      outQ[wrPtr] <= rspIn;           // credit guarantees a free slot
   end
end

// ==============================
// queue pointers and credit
// ==============================

assign pop = outFabricValid && fabReady;

always_ff @(posedge Clock or negedge arstN) begin
   if (!arstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      outCnt    <= '0;
      creditCnt <= '0;
   end else begin
      if (push) begin
         wrPtr <= (wrPtr == PtrW'(OutDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
         rdPtr <= (rdPtr == PtrW'(OutDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
         2'b10:   outCnt <= outCnt + 1'b1;
         2'b01:   outCnt <= outCnt - 1'b1;
         default: outCnt <= outCnt;
      endcase
      case ({issue, pop})             // credit back only when it leaves the tile
         2'b10:   creditCnt <= creditCnt + 1'b1;
         2'b01:   creditCnt <= creditCnt - 1'b1;
         default: creditCnt <= creditCnt;
      endcase
   end
end

// ==============================
// response formatting
// ==============================

assign headRsp        = outQ[rdPtr];
assign outFabricValid = (outCnt != '0);

always_comb begin
   outFabric       = '0;
   outFabric.dst   = headRsp.requester;   // back to whoever asked
   outFabric.src   = localTileId;
   outFabric.tag   = headRsp.tag;
   outFabric.op    = headRsp.op;
   outFabric.dataA = headRsp.result;
   outFabric.dataB = '0;
end

endmodule

// File: logic/accelTileTop.sv
`timescale 1ns/1ns

module accelTileTop (
   input  logic                    Clock          ,
   input  logic                    arstN          ,
   input  var accelPkg::tileIdT    localTileId    ,
   // ==============================
   // fabric in
   // ==============================
   input  logic                    inFabricValid  ,
   input  var accelPkg::tileTransT inFabric       ,
   output logic                    inFabricReady  ,
   // ==============================
   // fabric out
   // ==============================
   output logic                    outFabricValid ,
   output accelPkg::tileTransT     outFabric      ,
   input  logic                    fabReady
);

logic              ingValid;      // ingress -> buffer
accelPkg::mulReqT  ingReq;
logic              ingReady;
logic              fifoValid;     // buffer -> multiplier
accelPkg::mulReqT  fifoReq;
logic              fifoReady;

fabricIngress fabricIngress (
   .Clock          ( Clock          ),
   .arstN          ( arstN          ),
   .localTileId    ( localTileId    ),
   .inFabricValid  ( inFabricValid  ),
   .inFabric       ( inFabric       ),
   .inFabricReady  ( inFabricReady  ),
   .ingValid       ( ingValid       ),
   .ingReq         ( ingReq         ),
   .ingReady       ( ingReady       )
);

reqFifo reqFifo (
   .Clock          ( Clock          ),
   .arstN          ( arstN          ),
   .ingValid       ( ingValid       ),
   .ingReq         ( ingReq         ),
   .ingReady       ( ingReady       ),
   .fifoValid      ( fifoValid      ),
   .fifoReq        ( fifoReq        ),
   .fifoReady      ( fifoReady      )
);

mulUnit mulUnit (
   .Clock          ( Clock          ),
   .arstN          ( arstN          ),
   .localTileId    ( localTileId    ), // src of every response
   .fifoValid      ( fifoValid      ),
   .fifoReq        ( fifoReq        ),
   .fifoReady      ( fifoReady      ),
   .outFabricValid ( outFabricValid ),
   .outFabric      ( outFabric      ),
   .fabReady       ( fabReady       )
);

endmodule

// File: bench/accelTile_assertions.sv
`timescale 1ns/1ns
`include "accel_cfg.svh"

module accelTileAssertions (
   input  logic                    Clock          ,
   input  logic                    arstN          ,
   input  logic                    inFabricReady  ,
   input  logic                    ingValid       ,
   input  logic                    ingReady       ,
   input  var accelPkg::mulReqT    ingReq         ,
   input  logic                    fifoValid      ,
   input  logic                    fifoReady      ,
   input  var accelPkg::mulReqT    fifoReq        ,
   input  logic                    outFabricValid ,
   input  logic                    fabReady       ,
   input  var accelPkg::tileTransT outFabric      ,
   input  logic [$clog2(`ACCEL_FIFO_DEPTH + 1)-1:0] fifoCount
);

int failCount = 0;                    // polled by the bench

// ==============================
// valid/ready hold rules
// ==============================

ingHold: assert property (@(posedge Clock) disable iff (!arstN)
   (ingValid && !ingReady) |=> (ingValid && $stable(ingReq)))
   else begin
      failCount++;
      $error("ingReq dropped or changed while stalled");
   end

fifoHold: assert property (@(posedge Clock) disable iff (!arstN)
   (fifoValid && !fifoReady) |=> (fifoValid && $stable(fifoReq)))
   else begin
      failCount++;
      $error("fifoReq dropped or changed while stalled");
   end

outHold: assert property (@(posedge Clock) disable iff (!arstN)
   (outFabricValid && !fabReady) |=> (outFabricValid && $stable(outFabric)))
   else begin
      failCount++;
      $error("outFabric dropped or changed while fabric stalled");
   end

// ==============================
// reset and occupancy
// ==============================

resetQuiet: assert property (@(posedge Clock)
   $rose(arstN) |-> (!inFabricReady && !ingValid && !fifoValid && !outFabricValid &&
                     fifoReady))
   else begin
      failCount++;
      $error("a valid or the fabric ready was high in the first cycle out of reset");
   end

fifoBound: assert property (@(posedge Clock) disable iff (!arstN)
   fifoCount <= `ACCEL_FIFO_DEPTH)
   else begin
      failCount++;
      $error("request buffer count above its depth");
   end

endmodule

bind accelTileTop accelTileAssertions handshakeChk (
   .Clock          ( Clock          ),
   .arstN          ( arstN          ),
   .inFabricReady  ( inFabricReady  ),
   .ingValid       ( ingValid       ),
   .ingReady       ( ingReady       ),
   .ingReq         ( ingReq         ),
   .fifoValid      ( fifoValid      ),
   .fifoReady      ( fifoReady      ),
   .fifoReq        ( fifoReq        ),
   .outFabricValid ( outFabricValid ),
   .fabReady       ( fabReady       ),
   .outFabric      ( outFabric      ),
   .fifoCount      ( reqFifo.count  )  // internal occupancy of the buffer
);

// File: bench/accelTileTb.sv
`timescale 1ns/1ns
`include "accel_cfg.svh"

module accelTileTb;

localparam int Period    = 100;
localparam int NumCorner = 5;
localparam int NumMixed  = 40;
localparam int NumBurst  = 40;
localparam int NumPress  = 60;
localparam int NumTrans  = 4 * NumCorner * NumCorner + NumMixed + NumBurst + NumPress;
localparam accelPkg::tileIdT LocalId = 4'b1001;   // x 2, y 1

logic                Clock;
logic                arstN;
logic                inFabricValid;
accelPkg::tileTransT inFabric;
logic                inFabricReady;
logic                outFabricValid;
accelPkg::tileTransT outFabric;
logic                fabReady;

logic [31:0]         stimState  = 32'hfc9f_fe5d;   // operands, ops, tags, routes
logic [31:0]         pressState = ~32'hfc9f_fe5d;  // fabReady pattern
accelPkg::tileTransT expQ [$];                     // responses still owed
int                  fabMode;                      // 0 ready, 1 random, 2 long stalls
int                  stretchLeft;
int                  stallSeen;                    // ingress back-pressure cycles
logic [31:0]         corner [NumCorner];

accelTileTop u_dut (
   .Clock          ( Clock          ),
   .arstN          ( arstN          ),
   .localTileId    ( LocalId        ),
   .inFabricValid  ( inFabricValid  ),
   .inFabric       ( inFabric       ),
   .inFabricReady  ( inFabricReady  ),
   .outFabricValid ( outFabricValid ),
   .outFabric      ( outFabric      ),
   .fabReady       ( fabReady       )
);

initial begin
   Clock = 1'b0;
   forever #(Period / 2) Clock = ~Clock;
end

// ==============================
// helpers
// ==============================

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s ^ (s << 13);
   x = x ^ (x >> 17);
   return x ^ (x << 5);
endfunction

function automatic logic [31:0] nextRandom();
   stimState = xorshift32(stimState);
   return stimState;
endfunction

// product taken modulo 2^64 from the extended operands
function automatic logic [31:0] expectedResult(input accelPkg::mulOpT op,
                                               input logic [31:0] a, input logic [31:0] b);
   logic        signA;
   logic        signB;
   logic [63:0] prod;
   signA = (op == accelPkg::opMulh) || (op == accelPkg::opMulhsu);
   signB = (op == accelPkg::opMulh);
   prod  = {{32{signA & a[31]}}, a} * {{32{signB & b[31]}}, b};
   return (op == accelPkg::opMul) ? prod[31:0] : prod[63:32];
endfunction

function automatic accelPkg::tileTransT expectedResponse(input accelPkg::tileTransT t);
   accelPkg::tileTransT r;
   r       = '0;
   r.dst   = t.src;                   // back to the requester
   r.src   = LocalId;
   r.tag   = t.tag;
   r.op    = t.op;
   r.dataA = expectedResult(t.op, t.dataA, t.dataB);
   return r;
endfunction

function automatic accelPkg::tileTransT buildTrans(input accelPkg::tileIdT dst,
      input accelPkg::mulOpT op, input logic [31:0] a, input logic [31:0] b);
   accelPkg::tileTransT t;
   logic [31:0]         r;
   r       = nextRandom();
   t       = '0;
   t.dst   = dst;
   t.src   = r[3:0];                  // any requester, may be us
   t.tag   = r[7:4];
   t.op    = op;
   t.dataA = a;
   t.dataB = b;
   return t;
endfunction

function automatic accelPkg::tileIdT otherTile();
   accelPkg::tileIdT id;
   logic [31:0]      r;
   id = LocalId;
   while (id == LocalId) begin
      r  = nextRandom();
      id = r[3:0];
   end
   return id;
endfunction

task automatic abortRun();
   $display("TESTBENCH FAILED");
   $fatal(1, "run stopped at the first error");
endtask

task automatic compareField(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (exp === act) else begin
      $display("error: %s expected 0x%h actual 0x%h", name, exp, act);
      abortRun();
   end
endtask

// holds valid until the tile takes it, ready sampled mid-cycle
task automatic sendTrans(input accelPkg::tileTransT t);
   logic taken;
   taken         = 1'b0;
   inFabricValid = 1'b1;
   inFabric      = t;
   while (!taken) begin
      @(negedge Clock);
      taken = inFabricReady;
      if (!taken) stallSeen++;
      if (taken && t.dst == LocalId) expQ.push_back(expectedResponse(t));
      @(posedge Clock);
      #5;
   end
   inFabricValid = 1'b0;
endtask

// ==============================
// response checker
// ==============================

always @(negedge Clock) begin
   accelPkg::tileTransT exp;
   if (arstN && outFabricValid && fabReady) begin      // transfer at next edge
      assert (expQ.size() != 0) else begin
         $display("error: response 0x%h arrived with no request owed", outFabric);
         abortRun();
      end
      exp = expQ.pop_front();
      compareField("outFabric.dst", 32'(exp.dst), 32'(outFabric.dst));
      compareField("outFabric.src", 32'(exp.src), 32'(outFabric.src));
      compareField("outFabric.tag", 32'(exp.tag), 32'(outFabric.tag));
      compareField("outFabric.op", 32'(exp.op), 32'(outFabric.op));
      compareField("outFabric.dataA", exp.dataA, outFabric.dataA);
      compareField("outFabric.dataB", exp.dataB, outFabric.dataB);
      compareField("outFabric.rsvd", 32'(exp.rsvd), 32'(outFabric.rsvd));
   end
   if (u_dut.handshakeChk.failCount != 0) begin
      $display("error: a handshake, reset or occupancy assertion in the tile failed");
      abortRun();
   end
end

// ==============================
// fabReady pattern
// ==============================

initial begin
   fabReady    = 1'b1;
   stretchLeft = 0;
   forever begin
      @(posedge Clock);
      #5;
      pressState = xorshift32(pressState);
      if (fabMode == 0) begin
         fabReady = 1'b1;
      end else if (fabMode == 1) begin
         fabReady = (pressState[1:0] != 2'b00);          // ready 3 of 4
      end else if (stretchLeft == 0) begin
         fabReady    = !fabReady;
         stretchLeft = fabReady ? 2 + int'(pressState[2:0]) : 20 + int'(pressState[4:0]);
      end else begin
         stretchLeft--;
      end
   end
end

// ==============================
// main sequence
// ==============================

initial begin
   logic [31:0] r;
   arstN         = 1'b0;
   inFabricValid = 1'b0;
   inFabric      = '0;
   fabMode       = 0;
   stallSeen     = 0;
   corner        = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h0};
   corner[4]     = nextRandom();
   repeat (3) @(posedge Clock);
   #5 arstN = 1'b1;
   @(posedge Clock);                  // ingress opens one cycle after reset
   #5;
   for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < NumCorner; i++) begin
         for (int j = 0; j < NumCorner; j++) begin
            sendTrans(buildTrans(LocalId, accelPkg::mulOpT'(op), corner[i], corner[j]));
         end
      end
   end
   for (int k = 0; k < NumMixed; k++) begin     // about half misrouted
      r = nextRandom();
      sendTrans(buildTrans(r[0] ? LocalId : otherTile(), accelPkg::mulOpT'(r[2:1]),
                           nextRandom(), nextRandom()));
   end
   for (int k = 0; k < NumBurst; k++) begin     // back to back, fabric always ready
      r = nextRandom();
      sendTrans(buildTrans(LocalId, accelPkg::mulOpT'(r[1:0]), nextRandom(), nextRandom()));
   end
   for (int k = 0; k < NumPress; k++) begin
      fabMode = (k < NumPress / 2) ? 2 : 1;     // long stalls, then random
      r = nextRandom();
      sendTrans(buildTrans(r[5] ? LocalId : otherTile(), accelPkg::mulOpT'(r[1:0]),
                           nextRandom(), nextRandom()));
   end
   fabMode = 0;
   while (expQ.size() != 0) @(posedge Clock);
   repeat (20) @(posedge Clock);      // room for a stray extra response
   if (stallSeen > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
   end else begin
      $display("error: back-pressure never reached the ingress port");
      abortRun();
   end
end

// ==============================
// watchdog
// ==============================

initial begin
   #(Period * (NumTrans * (`ACCEL_MUL_STAGES + 20) + 200));
   $display("error: timeout, responses stopped before all requests were answered");
   abortRun();
end

endmodule

// File: accelTileTop.f
+incdir+logic
logic/accelPkg.sv
logic/fabricIngress.sv
logic/reqFifo.sv
logic/mulUnit.sv
logic/accelTileTop.sv
bench/accelTile_assertions.sv
bench/accelTileTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = accelTileTb
FILELIST = accelTileTop.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
